/* cmd_pkg.sv */
package cmd_pkg;

  // idle cycles between the address frame and the data frame of a write
  localparam int FRAME_GAP = 5;

  // cycles from the end of the address frame until a reply must start
  localparam int RESP_TIMEOUT = 200;

  localparam int GAP_W = $clog2(FRAME_GAP);
  localparam int TMO_W = $clog2(RESP_TIMEOUT);

  typedef struct packed {
    logic       is_write;
    logic [6:0] addr;
    logic [7:0] wdata;
  } wr_cmd_t;

  typedef struct packed {
    logic       is_write;
    logic [6:0] addr;
    logic [7:0] reserved;
  } rd_cmd_t;

  // top bit selects which view is meaningful
  typedef union packed {
    wr_cmd_t wr;
    rd_cmd_t rd;
  } cmd_word_t;

  typedef struct packed {
    logic       is_read;
    logic [7:0] rdata;
    logic       parity_err;
    logic       timeout;
  } resp_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f tb.f --top-module tb_top -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if grep -qx "Test passed" <<< "$out"; then
  exit 0
fi
exit 1

/* tb.f */
uart_pkg.sv
cmd_pkg.sv
uart_tx.sv
uart_rx.sv
uart_cmd_ctrl.sv
uart_cmd_bridge.sv
tb_checker.sv
tb_top.sv

/* tb_checker.sv */
module tb_checker
  import uart_pkg::*;
  import cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      tx,
  input  logic      busy,
  input  logic      done,
  input  resp_t     resp,
  input  cmd_word_t exp_cmd,
  input  resp_t     exp_resp,
  input  logic      test_start,
  input  logic      run_end,
  output int        pass_count,
  output int        fail_count
);

  timeunit 1ns;
  timeprecision 100ps;

  logic        live;
  logic        end_seen;
  int          started;
  cmd_word_t   exp_cmd_q;
  resp_t       exp_resp_q;
  int          closed;
  int          frames_seen;
  logic        test_bad;
  logic        reset_checked;
  logic        in_frame;
  int          tick;
  int          nbit;
  logic [10:0] bits;

  // testbench strobes are taken on the rising edge
  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      live     <= 1'b0;
      end_seen <= 1'b0;
      started  <= 0;
    end
    else
    begin
      live <= 1'b1;
      if (test_start)
      begin
        exp_cmd_q  <= exp_cmd;
        exp_resp_q <= exp_resp;
        started    <= started + 1;
      end
      if (run_end)
      begin
        end_seen <= 1'b1;
      end
    end
  end

  function automatic int frames_expected();
    return exp_cmd_q.wr.is_write ? 2 : 1;
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] want,
                               input logic [31:0] got);
    $display("Mismatch at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, want, got);
    test_bad = 1'b1;
  endtask

  task automatic close_test();
    if (test_bad)
    begin
      $display("test %0d failed", closed + 1);
      fail_count++;
    end
    else
    begin
      $display("test %0d passed", closed + 1);
      pass_count++;
    end
    closed++;
    frames_seen = 0;
    test_bad    = 1'b0;
  endtask

  task automatic check_reset();
    reset_checked = 1'b1;
    if (tx !== 1'b1)
    begin
      flag_mismatch("tx", 32'd1, 32'(tx));
    end
    if (busy !== 1'b0)
    begin
      flag_mismatch("busy", 32'd0, 32'(busy));
    end
    if (done !== 1'b0)
    begin
      flag_mismatch("done", 32'd0, 32'(done));
    end
    if (test_bad)
    begin
      $display("reset check failed");
      fail_count++;
    end
    else
    begin
      $display("reset check passed");
      pass_count++;
    end
    test_bad = 1'b0;
  endtask

  task automatic check_frame();
    logic [7:0] data;
    logic [7:0] want;
    data = bits[8:1];
    if (started == closed)
    begin
      $display("Frame 0x%02h on tx at %0t with no command outstanding", data, $time);
      fail_count++;
    end
    else if (frames_seen >= frames_expected())
    begin
      $display("test %0d: extra frame 0x%02h on tx at %0t", closed + 1, data, $time);
      test_bad = 1'b1;
    end
    else
    begin
      want = (frames_seen == 0) ? {exp_cmd_q.wr.is_write, exp_cmd_q.wr.addr} :
                                  exp_cmd_q.wr.wdata;
      if (bits[0] !== 1'b0)
      begin
        $display("test %0d: start bit on tx did not hold to mid-bit at %0t", closed + 1, $time);
        test_bad = 1'b1;
      end
      if (data !== want)
      begin
        flag_mismatch("tx data", 32'(want), 32'(data));
      end
      // nine data and parity bits hold an odd count of ones
      if (^bits[9:1] !== 1'b1)
      begin
        flag_mismatch("tx parity", 32'(~^data), 32'(bits[9]));
      end
      if (bits[10] !== 1'b1)
      begin
        flag_mismatch("tx stop", 32'd1, 32'(bits[10]));
      end
    end
    frames_seen++;
  endtask

  // mid-bit sampler, tick 1 is the first low sample of the start bit
  task automatic decode_tx();
    if (!in_frame)
    begin
      if (tx === 1'b0)
      begin
        in_frame = 1'b1;
        tick     = 1;
        nbit     = 0;
      end
    end
    else
    begin
      tick++;
      if (tick == HALF_DIV + 1 + nbit * BAUD_DIV)
      begin
        bits = {tx, bits[10:1]};
        if (nbit == FRAME_BITS - 1)
        begin
          in_frame = 1'b0;
          check_frame();
        end
        else
        begin
          nbit++;
        end
      end
    end
  endtask

  task automatic check_done();
    if (started == closed)
    begin
      $display("done pulsed at %0t with no command outstanding", $time);
      fail_count++;
    end
    else
    begin
      if (frames_seen != frames_expected())
      begin
        $display("test %0d: %0d tx frames before done, expected %0d",
                 closed + 1, frames_seen, frames_expected());
        test_bad = 1'b1;
      end
      if (resp.is_read !== exp_resp_q.is_read)
      begin
        flag_mismatch("resp.is_read", 32'(exp_resp_q.is_read), 32'(resp.is_read));
      end
      if (resp.rdata !== exp_resp_q.rdata)
      begin
        flag_mismatch("resp.rdata", 32'(exp_resp_q.rdata), 32'(resp.rdata));
      end
      if (resp.parity_err !== exp_resp_q.parity_err)
      begin
        flag_mismatch("resp.parity_err", 32'(exp_resp_q.parity_err), 32'(resp.parity_err));
      end
      if (resp.timeout !== exp_resp_q.timeout)
      begin
        flag_mismatch("resp.timeout", 32'(exp_resp_q.timeout), 32'(resp.timeout));
      end
      close_test();
    end
  endtask

  // DUT outputs are sampled on the falling edge
  always @(negedge clk)
  begin
    if (!live)
    begin
      closed        = 0;
      frames_seen   = 0;
      test_bad      = 1'b0;
      reset_checked = 1'b0;
      in_frame      = 1'b0;
      tick          = 0;
      nbit          = 0;
      bits          = '1;
      pass_count    = 0;
      fail_count    = 0;
    end
    else
    begin
      if (!reset_checked)
      begin
        check_reset();
      end
      if (started > closed + 1 || (end_seen && started > closed))
      begin
        $display("test %0d: no done was seen for this command", closed + 1);
        test_bad = 1'b1;
        close_test();
      end
      decode_tx();
      if (done === 1'b1)
      begin
        check_done();
      end
    end
  end

endmodule

/* tb_top.sv */
module tb_top
  import uart_pkg::*;
  import cmd_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_TESTS     = 8;
  localparam int RST_CYCLES  = 16;
  localparam int TEST_CYCLES = 3 * FRAME_BITS * BAUD_DIV + RESP_TIMEOUT + 100;
  // strobe, launch and tx_start come ahead of the address frame
  localparam int ADDR_END    = 3 + FRAME_BITS * BAUD_DIV;

  typedef enum logic [1:0] {
    REPLY_NONE,
    REPLY_GOOD,
    REPLY_BAD,
    REPLY_SILENT
  } reply_t;

  typedef struct packed {
    cmd_word_t  cmd;
    reply_t     mode;
    logic [7:0] reply;
    logic [7:0] delay;
    logic       dup;
  } entry_t;

  logic        clk;
  logic        rst_n;
  cmd_word_t   cmd;
  logic        cmd_valid;
  logic        busy;
  logic        done;
  resp_t       resp;
  logic        tx;
  logic        rx;
  cmd_word_t   exp_cmd;
  resp_t       exp_resp;
  logic        test_start;
  logic        run_end;
  int          pass_count;
  int          fail_count;
  logic [31:0] lfsr;
  entry_t      stim[$];

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #2 clk = ~clk;
    end
  end

  uart_cmd_bridge u_uart_cmd_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .done      (done),
    .resp      (resp),
    .tx        (tx),
    .rx        (rx)
  );

  tb_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .busy       (busy),
    .done       (done),
    .resp       (resp),
    .exp_cmd    (exp_cmd),
    .exp_resp   (exp_resp),
    .test_start (test_start),
    .run_end    (run_end),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic add_entry(input reply_t mode, input logic [7:0] delay, input logic dup);
    entry_t     e;
    logic [7:0] addr;
    logic [7:0] data;
    logic [7:0] reply;
    take_bits(7, addr);
    take_bits(8, data);
    take_bits(8, reply);
    e                 = '0;
    e.cmd.wr.is_write = (mode == REPLY_NONE);
    e.cmd.wr.addr     = addr[6:0];
    // reads leave the low byte at zero
    e.cmd.wr.wdata    = (mode == REPLY_NONE) ? data : 8'h00;
    e.mode            = mode;
    e.reply           = (mode == REPLY_GOOD || mode == REPLY_BAD) ? reply : 8'h00;
    e.delay           = delay;
    e.dup             = dup;
    stim.push_back(e);
  endtask

  function automatic resp_t expect_resp(input entry_t e);
    resp_t r;
    r = '0;
    case (e.mode)
      REPLY_GOOD:
      begin
        r.is_read = 1'b1;
        r.rdata   = e.reply;
      end
      REPLY_BAD:
      begin
        r.is_read    = 1'b1;
        r.rdata      = e.reply;
        r.parity_err = 1'b1;
      end
      REPLY_SILENT:
      begin
        r.is_read = 1'b1;
        r.timeout = 1'b1;
      end
      default:
      begin
        r = '0;
      end
    endcase
    return r;
  endfunction

  // remote device answer, odd parity unless bad is set
  task automatic send_reply(input logic [7:0] data, input logic bad);
    logic [10:0] frame;
    frame = {1'b1, (~^data) ^ bad, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx = frame[0];
      frame = frame >> 1;
      repeat (BAUD_DIV) @(negedge clk);
    end
  endtask

  task automatic run_entry(input entry_t e);
    int elapsed;
    while (busy)
    begin
      @(negedge clk);
    end
    @(negedge clk);
    cmd        = e.cmd;
    cmd_valid  = 1'b1;
    exp_cmd    = e.cmd;
    exp_resp   = expect_resp(e);
    test_start = 1'b1;
    @(negedge clk);
    cmd_valid  = 1'b0;
    test_start = 1'b0;
    elapsed    = 1;
    if (e.dup)
    begin
      // second strobe while busy, must be dropped
      repeat (8) @(negedge clk);
      cmd       = ~e.cmd;
      cmd_valid = 1'b1;
      @(negedge clk);
      cmd_valid = 1'b0;
      elapsed   = 10;
    end
    if (e.mode == REPLY_GOOD || e.mode == REPLY_BAD)
    begin
      repeat (ADDR_END - elapsed + e.delay) @(negedge clk);
      send_reply(e.reply, e.mode == REPLY_BAD);
    end
  endtask

  initial
  begin
    rst_n      = 1'b0;
    cmd        = '0;
    cmd_valid  = 1'b0;
    rx         = 1'b1;
    exp_cmd    = '0;
    exp_resp   = '0;
    test_start = 1'b0;
    run_end    = 1'b0;
    lfsr       = 32'h346210a7;
    // reply mode, reply delay after the address frame, extra strobe
    add_entry(REPLY_NONE,   8'd0,  1'b0);
    add_entry(REPLY_NONE,   8'd0,  1'b1);
    add_entry(REPLY_GOOD,   8'd5,  1'b0);
    add_entry(REPLY_BAD,    8'd20, 1'b0);
    add_entry(REPLY_SILENT, 8'd0,  1'b0);
    add_entry(REPLY_GOOD,   8'd40, 1'b1);
    add_entry(REPLY_NONE,   8'd0,  1'b0);
    add_entry(REPLY_GOOD,   8'd2,  1'b0);
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);
    foreach (stim[i])
    begin
      run_entry(stim[i]);
    end
    while (busy)
    begin
      @(negedge clk);
    end
    // leave room for a stray frame or done
    repeat (FRAME_BITS * BAUD_DIV + 16) @(negedge clk);
    run_end = 1'b1;
    @(negedge clk);
    run_end = 1'b0;
    repeat (2) @(negedge clk);
    @(posedge clk);
    $display("%0d checks passed, %0d failed", pass_count, fail_count);
    // reset check plus one per table entry
    if (fail_count == 0 && pass_count == stim.size() + 1)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

  initial
  begin
    repeat (RST_CYCLES + N_TESTS * TEST_CYCLES) @(posedge clk);
    $display("Timeout: run still going after %0d cycles", RST_CYCLES + N_TESTS * TEST_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

/* uart_cmd_bridge.sv */
module uart_cmd_bridge
  import uart_pkg::*;
  import cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  cmd_word_t cmd,
  input  logic      cmd_valid,
  output logic      busy,
  output logic      done,
  output resp_t     resp,
  output logic      tx,
  input  logic      rx
);

  logic [7:0] tx_byte;
  logic       tx_start;
  logic       tx_done;
  logic       rx_enable;
  logic       rx_active;
  logic       rx_valid;
  rx_byte_t   rx_result;

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .busy      (busy),
    .done      (done),
    .resp      (resp),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_done   (tx_done),
    .rx_enable (rx_enable),
    .rx_active (rx_active),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

  uart_tx u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // only listens while a read waits for its reply
  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_enable (rx_enable),
    .rx_active (rx_active),
    .rx_valid  (rx_valid),
    .rx_result (rx_result)
  );

endmodule

/* uart_cmd_ctrl.sv */
module uart_cmd_ctrl
  import uart_pkg::*;
  import cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_word_t  cmd,
  input  logic       cmd_valid,
  output logic       busy,
  output logic       done,
  output resp_t      resp,
  output logic [7:0] tx_byte,
  output logic       tx_start,
  input  logic       tx_done,
  output logic       rx_enable,
  input  logic       rx_active,
  input  logic       rx_valid,
  input  rx_byte_t   rx_result
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_GAP,
    S_DATA,
    S_WAIT,
    S_RECV,
    S_FINISH
  } state_t;

  state_t           state;
  cmd_word_t        cmd_q;
  logic             launch;
  logic [GAP_W-1:0] gap_cnt;
  logic [TMO_W-1:0] tmo_cnt;
  logic             accept;
  logic             gap_end;
  logic             tmo_hit;

  // finish is the done cycle, busy is already low there
  assign busy      = (state != S_IDLE) && (state != S_FINISH);
  assign done      = (state == S_FINISH);
  assign accept    = cmd_valid && !busy;
  assign rx_enable = (state == S_WAIT) || (state == S_RECV);
  assign gap_end   = (state == S_GAP) && (gap_cnt == GAP_W'(FRAME_GAP - 1));
  assign tmo_hit   = (state == S_WAIT) && !rx_active &&
                     (tmo_cnt == TMO_W'(RESP_TIMEOUT - 1));

  // header byte is laid out the same in both views
  assign tx_byte = (state == S_GAP || state == S_DATA) ? cmd_q.wr.wdata :
                   {cmd_q.rd.is_write, cmd_q.rd.addr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      launch   <= 1'b0;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
      tmo_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      launch   <= 1'b0;
      case (state)
        S_IDLE, S_FINISH:
        begin
          if (accept)
          begin
            state  <= S_ADDR;
            launch <= 1'b1;
          end
          else
          begin
            state <= S_IDLE;
          end
        end
        S_ADDR:
        begin
          if (launch)
          begin
            tx_start <= 1'b1;
          end
          if (tx_done)
          begin
            if (cmd_q.wr.is_write)
            begin
              state   <= S_GAP;
              // counts cycles since tx_done
              gap_cnt <= GAP_W'(1);
            end
            else
            begin
              state   <= S_WAIT;
              tmo_cnt <= '0;
            end
          end
        end
        S_GAP:
        begin
          if (gap_end)
          begin
            state    <= S_DATA;
            tx_start <= 1'b1;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        S_DATA:
        begin
          if (tx_done)
          begin
            state <= S_FINISH;
          end
        end
        S_WAIT:
        begin
          if (rx_active)
          begin
            state <= S_RECV;
          end
          else if (tmo_hit)
          begin
            state <= S_FINISH;
          end
          else
          begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        S_RECV:
        begin
          if (rx_valid)
          begin
            state <= S_FINISH;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q <= cmd;
    end
    if (state == S_DATA && tx_done)
    begin
      resp <= '0;
    end
    else if (tmo_hit)
    begin
      resp <= '{is_read: 1'b1, rdata: 8'h00, parity_err: 1'b0, timeout: 1'b1};
    end
    else if (state == S_RECV && rx_valid)
    begin
      resp <= '{is_read:    1'b1,
                rdata:      rx_result.data,
                parity_err: rx_result.parity_err,
                timeout:    1'b0};
    end
  end

endmodule

/* uart_pkg.sv */
package uart_pkg;

  // clock cycles per bit, kept small so simulation stays short
  localparam int BAUD_DIV = 8;

  // mid-bit sample point
  localparam int HALF_DIV = BAUD_DIV / 2;

  // start, eight data, parity, stop
  localparam int FRAME_BITS = 11;

  // bit-period counter width
  localparam int CNT_W = $clog2(BAUD_DIV);

  // bit index width across a whole frame
  localparam int IDX_W = $clog2(FRAME_BITS);

  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;
  } rx_byte_t;

endpackage

/* uart_rx.sv */
module uart_rx
  import uart_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     rx,
  input  logic     rx_enable,
  output logic     rx_active,
  output logic     rx_valid,
  output rx_byte_t rx_result
);

  typedef enum logic [2:0] {
    R_IDLE,
    R_START,
    R_DATA,
    R_PARITY,
    R_STOP
  } rx_state_t;

  rx_state_t        state;
  logic [2:0]       sync;
  logic             rx_s;
  logic             fall;
  logic             sample;
  logic [CNT_W-1:0] baud_cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       data_sh;
  logic             parity_bit;

  // sync[1] is the synchronized line, sync[2] its previous value
  assign rx_s   = sync[1];
  assign fall   = sync[2] & ~sync[1];
  assign sample = (baud_cnt == CNT_W'(BAUD_DIV - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync <= '1;
    end
    else
    begin
      sync <= {sync[1:0], rx};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= R_IDLE;
      baud_cnt  <= '0;
      bit_idx   <= '0;
      rx_active <= 1'b0;
      rx_valid  <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (!rx_enable)
      begin
        state     <= R_IDLE;
        baud_cnt  <= '0;
        rx_active <= 1'b0;
      end
      else
      begin
        case (state)
          R_IDLE:
          begin
            if (fall)
            begin
              state    <= R_START;
              baud_cnt <= '0;
            end
          end
          R_START:
          begin
            if (baud_cnt == CNT_W'(HALF_DIV - 1))
            begin
              baud_cnt <= '0;
              // a line back high by mid-bit was only a glitch
              if (!rx_s)
              begin
                state     <= R_DATA;
                bit_idx   <= '0;
                rx_active <= 1'b1;
              end
              else
              begin
                state <= R_IDLE;
              end
            end
            else
            begin
              baud_cnt <= baud_cnt + 1'b1;
            end
          end
          R_DATA:
          begin
            if (sample)
            begin
              baud_cnt <= '0;
              if (bit_idx == 3'd7)
              begin
                state <= R_PARITY;
              end
              else
              begin
                bit_idx <= bit_idx + 1'b1;
              end
            end
            else
            begin
              baud_cnt <= baud_cnt + 1'b1;
            end
          end
          R_PARITY:
          begin
            if (sample)
            begin
              baud_cnt <= '0;
              state    <= R_STOP;
            end
            else
            begin
              baud_cnt <= baud_cnt + 1'b1;
            end
          end
          R_STOP:
          begin
            if (sample)
            begin
              baud_cnt  <= '0;
              state     <= R_IDLE;
              rx_active <= 1'b0;
              rx_valid  <= 1'b1;
            end
            else
            begin
              baud_cnt <= baud_cnt + 1'b1;
            end
          end
          default:
          begin
            state <= R_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_enable && sample)
    begin
      case (state)
        R_DATA:
        begin
          data_sh <= {rx_s, data_sh[7:1]};
        end
        R_PARITY:
        begin
          parity_bit <= rx_s;
        end
        R_STOP:
        begin
          rx_result.data       <= data_sh;
          // even ones count or a low stop bit
          rx_result.parity_err <= ~(^{data_sh, parity_bit}) | ~rx_s;
        end
        default:
        begin
          parity_bit <= parity_bit;
        end
      endcase
    end
  end

endmodule

/* uart_tx.sv */
module uart_tx
  import uart_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_byte,
  input  logic       tx_start,
  output logic       tx,
  output logic       tx_done
);

  logic                  active;
  logic [CNT_W-1:0]      baud_cnt;
  logic [IDX_W-1:0]      bit_idx;
  logic [FRAME_BITS-1:0] shreg;
  logic                  parity;
  logic                  bit_end;
  logic                  last_bit;

  // odd parity: data plus parity bit carry an odd number of ones
  assign parity   = ~^tx_byte;
  assign bit_end  = (baud_cnt == CNT_W'(BAUD_DIV - 1));
  assign last_bit = (bit_idx == IDX_W'(FRAME_BITS - 1));

  // bit 0 of the shift register is the line, idle fills it with ones
  assign tx      = shreg[0];
  assign tx_done = active && bit_end && last_bit;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      shreg    <= '1;
    end
    else if (!active)
    begin
      if (tx_start)
      begin
        active   <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
        // stop, parity, data lsb first, start
        shreg    <= {1'b1, parity, tx_byte, 1'b0};
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      shreg    <= {1'b1, shreg[FRAME_BITS-1:1]};
      if (last_bit)
      begin
        active <= 1'b0;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule
